// ==== dv/ycc_capture_assert.sv ====
//**********************************************************************
// Protocol checks for the capture front end, bound into the top
// level. Covers the last word, the address sequence, completion
// timing and quiet outputs outside a capture.
//**********************************************************************
`timescale 1ns/1ps

module ycc_capture_assert (
    input logic        clock_pixel_in,
    input logic        reset_pixel_n_in,
    input logic        capture_enable,
    input logic        data_valid_out,
    input logic        last_word,
    input logic        image_valid_out,
    input logic [15:0] address_out
);

    int unsigned failure_count = 0;
    logic        word_seen;      // a word of this capture already left
    logic [15:0] prev_address;

    always_ff @(posedge clock_pixel_in) begin
        if (!reset_pixel_n_in) begin
            word_seen    <= 1'b0;
            prev_address <= '0;
        end else if (data_valid_out) begin
            word_seen    <= !last_word;   // next capture starts at 0
            prev_address <= address_out;
        end
    end

    assert property (@(posedge clock_pixel_in) disable iff (!reset_pixel_n_in)
        last_word |-> data_valid_out)
    else begin
        failure_count++;
        $error("last_word came without data_valid_out");
    end

    assert property (@(posedge clock_pixel_in) disable iff (!reset_pixel_n_in)
        data_valid_out |-> address_out == (word_seen ? prev_address + 16'd4 : 16'd0))
    else begin
        failure_count++;
        $error("word address did not step by 4 from 0");
    end

    assert property (@(posedge clock_pixel_in) disable iff (!reset_pixel_n_in)
        last_word |=> image_valid_out)
    else begin
        failure_count++;
        $error("image_valid_out did not follow last_word");
    end

    assert property (@(posedge clock_pixel_in) disable iff (!reset_pixel_n_in)
        $rose(image_valid_out) |-> $past(last_word))
    else begin
        failure_count++;
        $error("image_valid_out rose without a last word");
    end

    assert property (@(posedge clock_pixel_in) disable iff (!reset_pixel_n_in)
        data_valid_out |-> capture_enable)
    else begin
        failure_count++;
        $error("data_valid_out high outside a capture");
    end

    // outputs quiet right after reset
    assert property (@(posedge clock_pixel_in)
        !reset_pixel_n_in |=> !data_valid_out && !image_valid_out)
    else begin
        failure_count++;
        $error("outputs not cleared by reset");
    end

endmodule

bind ycc_capture_top ycc_capture_assert u_ycc_capture_assert (
    .clock_pixel_in   (clock_pixel_in),
    .reset_pixel_n_in (reset_pixel_n_in),
    .capture_enable   (capture_enable),
    .data_valid_out   (data_valid_out),
    .last_word        (last_word),
    .image_valid_out  (image_valid_out),
    .address_out      (address_out)
);

// ==== dv/ycc_capture_tb.sv ====
//**********************************************************************
// Testbench for the capture front end. Drives random 8x5 frames at
// several compression factors and crop sizes, builds the expected
// byte stream and words from the conversion rules, and checks every
// word, the final byte count and the arming rules.
//**********************************************************************
`timescale 1ns/1ps

module ycc_capture_tb
    import ycc_capture_pkg::*;
();

    localparam int frame_cols = 8;
    localparam int frame_rows = 5;
    localparam int wait_limit = 400;   // cycles allowed for image_valid_out

    logic                    clock_pixel_in;
    logic                    reset_pixel_n_in;
    logic                    start_capture_in;
    logic [9:0]              red_data_in;
    logic [9:0]              green_data_in;
    logic [9:0]              blue_data_in;
    logic                    frame_valid_in;
    logic                    line_valid_in;
    logic [3:0]              compression_factor_in;
    logic [x_size_width-1:0] x_size_in;
    logic [y_size_width-1:0] y_size_in;
    logic [31:0]             data_out;
    logic [15:0]             address_out;
    logic                    data_valid_out;
    logic                    image_valid_out;

    logic [9:0]  red_mem [frame_cols * frame_rows];
    logic [9:0]  green_mem [frame_cols * frame_rows];
    logic [9:0]  blue_mem [frame_cols * frame_rows];
    logic [31:0] exp_data [$];
    logic [15:0] exp_addr [$];
    int          expected_total;
    int          seed = 32'h6e05;

    ycc_capture_top u_ycc_capture_top (
        .clock_pixel_in        (clock_pixel_in),
        .reset_pixel_n_in      (reset_pixel_n_in),
        .start_capture_in      (start_capture_in),
        .red_data_in           (red_data_in),
        .green_data_in         (green_data_in),
        .blue_data_in          (blue_data_in),
        .frame_valid_in        (frame_valid_in),
        .line_valid_in         (line_valid_in),
        .compression_factor_in (compression_factor_in),
        .x_size_in             (x_size_in),
        .y_size_in             (y_size_in),
        .data_out              (data_out),
        .address_out           (address_out),
        .data_valid_out        (data_valid_out),
        .image_valid_out       (image_valid_out)
    );

    initial begin
        clock_pixel_in = 1'b0;
        forever #2 clock_pixel_in = ~clock_pixel_in;
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        $display("Fail at %0t: %s is %h, expected %h", $time, name, got, expected);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic abort_run(input string reason);
        $display("Error at %0t: %s", $time, reason);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    // divide by 256 and clip to a byte
    function automatic int to_byte(input int sum);
        int scaled;
        scaled = sum >>> 8;
        if (scaled < 0) begin
            return 0;
        end else if (scaled > 255) begin
            return 255;
        end
        return scaled;
    endfunction

    task automatic build_expected(input int factor, input int xs, input int ys);
        logic [7:0]  bytes [$];
        logic [31:0] word;
        int          shift;
        int          idx;
        int          r8, g8, b8;
        shift = (factor > 7) ? 7 : factor;
        exp_data.delete();
        exp_addr.delete();
        for (int r = 0; r < frame_rows && r < ys; r++) begin
            for (int c = 0; c < frame_cols && c < xs; c++) begin
                idx = r * frame_cols + c;
                r8  = red_mem[idx][9:2];
                g8  = green_mem[idx][9:2];
                b8  = blue_mem[idx][9:2];
                bytes.push_back(8'(to_byte(77 * r8 + 150 * g8 + 29 * b8) >> shift));
                if (c % 2 == 0 && r % 2 == 0) begin   // 4:2:0 decimation
                    bytes.push_back(8'(to_byte(-43 * r8 - 85 * g8 + 128 * b8 + 32768) >> shift));
                    bytes.push_back(8'(to_byte(128 * r8 - 107 * g8 - 21 * b8 + 32768) >> shift));
                end
            end
        end
        expected_total = bytes.size();
        // a padded tail word, or a zero word when the count is a multiple of 4
        for (int w = 0; w < expected_total / 4 + 1; w++) begin
            word = '0;
            for (int k = 0; k < 4; k++) begin
                if (4 * w + k < expected_total) begin
                    word[8 * k +: 8] = bytes[4 * w + k];
                end
            end
            exp_data.push_back(word);
            exp_addr.push_back(16'(4 * w));
        end
    endtask

    task automatic drive_frame(input bit arm_early);
        @(posedge clock_pixel_in);
        frame_valid_in <= 1'b1;
        for (int r = 0; r < frame_rows; r++) begin
            repeat (3) @(posedge clock_pixel_in);   // line blanking
            if (arm_early && r == 2) begin
                start_capture_in <= 1'b1;   // request in mid frame
            end
            for (int c = 0; c < frame_cols; c++) begin
                @(posedge clock_pixel_in);
                line_valid_in <= 1'b1;
                red_data_in   <= red_mem[r * frame_cols + c];
                green_data_in <= green_mem[r * frame_cols + c];
                blue_data_in  <= blue_mem[r * frame_cols + c];
            end
            @(posedge clock_pixel_in);
            line_valid_in <= 1'b0;
        end
        repeat (2) @(posedge clock_pixel_in);
        if (arm_early) begin
            @(negedge clock_pixel_in);
            assert (image_valid_out)
            else abort_run("a start request was accepted during an active frame");
        end
        @(posedge clock_pixel_in);
        frame_valid_in <= 1'b0;
        @(posedge clock_pixel_in);
        start_capture_in <= 1'b0;
        repeat (4) @(posedge clock_pixel_in);
    endtask

    task automatic run_capture(input int factor, input int xs, input int ys,
                               input bit arm_early);
        int waited;
        build_expected(factor, xs, ys);
        @(posedge clock_pixel_in);
        compression_factor_in <= 4'(factor);
        x_size_in             <= x_size_width'(xs);
        y_size_in             <= y_size_width'(ys);
        if (arm_early) begin
            drive_frame(1'b1);   // this frame itself is not captured
        end else begin
            start_capture_in <= 1'b1;
            @(posedge clock_pixel_in);
            start_capture_in <= 1'b0;
        end
        drive_frame(1'b0);
        waited = 0;
        do begin
            @(negedge clock_pixel_in);
            waited++;
        end while (!image_valid_out && waited < wait_limit);
        if (!image_valid_out) begin
            abort_run("timed out waiting for image_valid_out after the frame");
        end
        assert (address_out == 16'(expected_total))
        else report_mismatch("address_out", 32'(address_out), 32'(expected_total));
        assert (exp_data.size() == 0)
        else abort_run("image_valid_out rose before all expected words arrived");
    endtask

    // word checker, outputs are stable at the falling edge
    always @(negedge clock_pixel_in) begin
        if (u_ycc_capture_top.u_ycc_capture_assert.failure_count != 0) begin
            abort_run("a protocol assertion in the bound checker failed");
        end
        if (data_valid_out) begin
            if (exp_data.size() == 0) begin
                abort_run("data_valid_out was high with no word expected");
            end else begin
                assert (data_out == exp_data[0])
                else report_mismatch("data_out", data_out, exp_data[0]);
                assert (address_out == exp_addr[0])
                else report_mismatch("address_out", 32'(address_out), 32'(exp_addr[0]));
                void'(exp_data.pop_front());
                void'(exp_addr.pop_front());
            end
        end
    end

    initial begin
        reset_pixel_n_in      = 1'b0;
        start_capture_in      = 1'b0;
        red_data_in           = '0;
        green_data_in         = '0;
        blue_data_in          = '0;
        frame_valid_in        = 1'b0;
        line_valid_in         = 1'b0;
        compression_factor_in = '0;
        x_size_in             = x_size_width'(frame_cols);
        y_size_in             = y_size_width'(frame_rows);
        for (int i = 0; i < frame_cols * frame_rows; i++) begin
            red_mem[i]   = 10'($random(seed));
            green_mem[i] = 10'($random(seed));
            blue_mem[i]  = 10'($random(seed));
        end
        repeat (5) @(posedge clock_pixel_in);
        reset_pixel_n_in <= 1'b1;

        run_capture(0, frame_cols, frame_rows, 1'b0);    // plain conversion
        run_capture(3, frame_cols, frame_rows, 1'b0);
        run_capture(12, frame_cols, frame_rows, 1'b0);   // clamps to 7
        run_capture(0, 5, 3, 1'b0);                      // cropped, partial tail word
        run_capture(2, frame_cols, frame_rows, 1'b1);    // start raised mid frame

        repeat (4) @(posedge clock_pixel_in);
        if (u_ycc_capture_top.u_ycc_capture_assert.failure_count == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("TESTS FAILED");
            $fatal(1);
        end
    end

endmodule

// ==== hw/capture_control.sv ====
//**********************************************************************
// Capture state machine. A start request arms one capture, which
// resets the datapath for a cycle, waits for the sensor frame and
// runs until the packer reports the last word. The image stays
// valid until the next accepted start request.
//**********************************************************************
`timescale 1ns/1ps

module capture_control
    import ycc_capture_pkg::*;
(
    input  logic clock_pixel_in,
    input  logic reset_pixel_n_in,
    input  logic start_capture_in,
    input  logic frame_valid_in,
    input  logic last_word,
    output logic datapath_reset_n,
    output logic capture_enable,
    output logic image_valid_out
);

    capture_state_t state;

    always_ff @(posedge clock_pixel_in) begin
        if (!reset_pixel_n_in) begin
            state <= idle;
        end else begin
            case (state)
                reset: begin
                    state <= wait_frame;   // one cycle of datapath reset
                end
                wait_frame: begin
                    if (frame_valid_in) begin
                        state <= compress;
                    end
                end
                compress: begin
                    // start requests are ignored here
                    if (last_word) begin
                        state <= image_valid;
                    end
                end
                default: begin   // idle and image_valid
                    // only arm between frames
                    if (start_capture_in && !frame_valid_in) begin
                        state <= reset;
                    end
                end
            endcase
        end
    end

    assign datapath_reset_n = (state != reset);
    assign capture_enable   = (state == wait_frame) || (state == compress);
    assign image_valid_out  = (state == image_valid);

endmodule

// ==== hw/color_quantizer.sv ====
//**********************************************************************
// Two-stage pixel pipeline. Crops the frame to the requested size,
// converts RGB to YCbCr, keeps chroma on even columns of even rows
// and quantizes each byte by a right shift. Byte lanes appear two
// cycles after the pixel; frame_done follows the frame end likewise.
//**********************************************************************
`timescale 1ns/1ps

module color_quantizer
    import ycc_capture_pkg::*;
(
    input  logic                    clock_pixel_in,
    input  logic                    reset_pixel_n_in,
    input  logic                    capture_enable,
    input  logic                    frame_valid_in,
    input  logic                    line_valid_in,
    input  logic [9:0]              red_data_in,
    input  logic [9:0]              green_data_in,
    input  logic [9:0]              blue_data_in,
    input  logic [3:0]              compression_factor_in,
    input  logic [x_size_width-1:0] x_size_in,
    input  logic [y_size_width-1:0] y_size_in,
    output logic [2:0]              byte_valid,   // lanes y, cb, cr
    output logic [2:0][7:0]         byte_lanes,
    output logic                    frame_done
);

    logic [x_size_width-1:0] column;
    logic [y_size_width-1:0] row;
    logic                    frame_valid_q;
    logic                    line_valid_q;
    logic                    frame_ended;
    logic                    active;
    logic                    pixel_take;
    logic                    frame_fall;
    logic [2:0]              shift;
    logic signed [17:0]      red_s;
    logic signed [17:0]      green_s;
    logic signed [17:0]      blue_s;
    logic                    s1_valid;
    logic                    s1_chroma;
    logic                    s1_frame_fall;
    logic signed [17:0]      s1_sum_y;
    logic signed [17:0]      s1_sum_cb;
    logic signed [17:0]      s1_sum_cr;

    // scale by 256 and clip to one byte
    function automatic logic [7:0] saturate(input logic signed [17:0] sum);
        logic signed [17:0] scaled;
        scaled = sum >>> 8;
        if (scaled < 0) begin
            return 8'd0;
        end else if (scaled > 255) begin
            return 8'd255;
        end else begin
            return scaled[7:0];
        end
    endfunction

    assign active     = capture_enable && !frame_ended;   // one frame per capture
    assign frame_fall = active && frame_valid_q && !frame_valid_in;
    assign pixel_take = active && frame_valid_in && line_valid_in
                        && (column < x_size_in) && (row < y_size_in);
    assign shift = (compression_factor_in > 4'(max_shift)) ? 3'(max_shift)
                                                           : compression_factor_in[2:0];

    // upper 8 bits of each color
    assign red_s   = 18'(red_data_in[9:2]);
    assign green_s = 18'(green_data_in[9:2]);
    assign blue_s  = 18'(blue_data_in[9:2]);

    always_ff @(posedge clock_pixel_in) begin
        if (!reset_pixel_n_in) begin
            column        <= '0;
            row           <= '0;
            frame_valid_q <= 1'b0;
            line_valid_q  <= 1'b0;
            frame_ended   <= 1'b0;
        end else begin
            frame_valid_q <= frame_valid_in;
            line_valid_q  <= line_valid_in;
            if (frame_fall) begin
                frame_ended <= 1'b1;
            end
            column <= line_valid_in ? column + 1'b1 : '0;
            if (!frame_valid_in) begin
                row <= '0;
            end else if (active && line_valid_q && !line_valid_in) begin
                row <= row + 1'b1;   // end of line
            end
        end
    end

    // stage one, weighted sums
    always_ff @(posedge clock_pixel_in) begin
        if (!reset_pixel_n_in) begin
            s1_valid      <= 1'b0;
            s1_frame_fall <= 1'b0;
        end else begin
            s1_valid      <= pixel_take;
            s1_frame_fall <= frame_fall;
        end
    end

    always_ff @(posedge clock_pixel_in) begin
        s1_chroma <= !column[0] && !row[0];
        s1_sum_y  <= 18'(y_weight_r * red_s + y_weight_g * green_s + y_weight_b * blue_s);
        s1_sum_cb <= 18'(cb_weight_r * red_s + cb_weight_g * green_s
                         + cb_weight_b * blue_s + chroma_offset * 256);
        s1_sum_cr <= 18'(cr_weight_r * red_s + cr_weight_g * green_s
                         + cr_weight_b * blue_s + chroma_offset * 256);
    end

    // stage two, clip, quantize and mark lanes
    always_ff @(posedge clock_pixel_in) begin
        if (!reset_pixel_n_in) begin
            byte_valid <= '0;
            frame_done <= 1'b0;
        end else begin
            byte_valid <= {s1_valid && s1_chroma, s1_valid && s1_chroma, s1_valid};
            frame_done <= s1_frame_fall;
        end
    end

    always_ff @(posedge clock_pixel_in) begin
        byte_lanes[0] <= saturate(s1_sum_y) >> shift;
        byte_lanes[1] <= saturate(s1_sum_cb) >> shift;
        byte_lanes[2] <= saturate(s1_sum_cr) >> shift;
    end

endmodule

// ==== hw/word_packer.sv ====
//**********************************************************************
// Packs the byte lanes into 32-bit words, first byte in bits 7:0.
// A word leaves the cycle after four bytes are held. At frame end
// the remainder goes out zero padded as the last word, and the
// address then settles on the total byte count.
//**********************************************************************
`timescale 1ns/1ps

module word_packer (
    input  logic            clock_pixel_in,
    input  logic            reset_pixel_n_in,
    input  logic [2:0]      byte_valid,
    input  logic [2:0][7:0] byte_lanes,
    input  logic            frame_done,
    output logic [31:0]     data_out,
    output logic [15:0]     address_out,
    output logic            data_valid_out,
    output logic            last_word
);

    logic [5:0][7:0] acc;
    logic [5:0][7:0] acc_next;
    logic [2:0]      count;        // bytes held in acc
    logic [2:0]      count_next;
    logic [2:0]      base;
    logic [2:0][7:0] new_bytes;
    logic [1:0]      new_count;
    logic            emit;
    logic            flush;
    logic            flush_pending;
    logic [3:0][7:0] tail_word;
    logic [15:0]     word_addr;    // address of the next word

    // compact valid lanes in order y, cb, cr
    always_comb begin
        new_count = '0;
        new_bytes = '0;
        for (int i = 0; i < 3; i++) begin
            if (byte_valid[i]) begin
                new_bytes[new_count] = byte_lanes[i];
                new_count = new_count + 1'b1;
            end
        end
    end

    always_comb begin
        emit     = (count >= 3'd4);
        flush    = (frame_done || flush_pending) && !emit;   // full words go first
        base     = emit ? count - 3'd4 : count;
        acc_next = emit ? (acc >> 32) : acc;
        for (int k = 0; k < 3; k++) begin
            if (k < new_count) begin
                acc_next[base + 3'(k)] = new_bytes[k];
            end
        end
        count_next = flush ? 3'd0 : base + 3'(new_count);
    end

    // bytes past the count are padding
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            tail_word[i] = (3'(i) < count) ? acc[i] : 8'h00;
        end
    end

    always_ff @(posedge clock_pixel_in) begin
        if (!reset_pixel_n_in) begin
            count          <= '0;
            flush_pending  <= 1'b0;
            data_valid_out <= 1'b0;
            last_word      <= 1'b0;
            word_addr      <= '0;
            address_out    <= '0;
        end else begin
            count          <= count_next;
            data_valid_out <= emit || flush;
            last_word      <= flush;
            if (flush) begin
                flush_pending <= 1'b0;
            end else if (frame_done) begin
                flush_pending <= 1'b1;
            end
            if (emit) begin
                address_out <= word_addr;
                word_addr   <= word_addr + 16'd4;
            end else if (flush) begin
                address_out <= word_addr;
                word_addr   <= word_addr + 16'(count);   // exact total, no padding
            end else if (last_word) begin
                address_out <= word_addr;   // hold total byte count
            end
        end
    end

    always_ff @(posedge clock_pixel_in) begin
        acc <= acc_next;
        if (emit) begin
            data_out <= acc[3:0];
        end else if (flush) begin
            data_out <= tail_word;
        end
    end

endmodule

// ==== hw/ycc_capture_pkg.sv ====
//**********************************************************************
// Shared constants and types for the YCbCr capture front end.
// Holds the sensor limits, the RGB to YCbCr weights and the capture
// state encoding. Modules pull these in with a wildcard import.
//**********************************************************************
package ycc_capture_pkg;

    // sensor limits
    localparam int sensor_x_size = 1280;
    localparam int sensor_y_size = 720;

    // width of the size inputs and of the column and row counters
    localparam int x_size_width = $clog2(sensor_x_size);
    localparam int y_size_width = $clog2(sensor_y_size);

    localparam int max_shift = 7;   // largest quantizer shift

    // luma weights, sum scaled by 256
    localparam int y_weight_r = 77;
    localparam int y_weight_g = 150;
    localparam int y_weight_b = 29;

    // blue difference weights
    localparam int cb_weight_r = -43;
    localparam int cb_weight_g = -85;
    localparam int cb_weight_b = 128;

    // red difference weights
    localparam int cr_weight_r = 128;
    localparam int cr_weight_g = -107;
    localparam int cr_weight_b = -21;

    localparam int chroma_offset = 128;   // added to cb and cr after scaling

    typedef enum logic [2:0] {idle, reset, wait_frame, compress, image_valid} capture_state_t;

endpackage

// ==== hw/ycc_capture_top.sv ====
//**********************************************************************
// Top level of the capture front end. Connects the sensor pixel
// port to the quantizer and packer under control of the capture
// state machine. Everything runs on the pixel clock and the output
// has no back-pressure.
//**********************************************************************
`timescale 1ns/1ps

module ycc_capture_top
    import ycc_capture_pkg::*;
(
    input  logic                    clock_pixel_in,
    input  logic                    reset_pixel_n_in,
    input  logic                    start_capture_in,
    input  logic [9:0]              red_data_in,
    input  logic [9:0]              green_data_in,
    input  logic [9:0]              blue_data_in,
    input  logic                    frame_valid_in,
    input  logic                    line_valid_in,
    input  logic [3:0]              compression_factor_in,
    input  logic [x_size_width-1:0] x_size_in,
    input  logic [y_size_width-1:0] y_size_in,
    output logic [31:0]             data_out,      // four bytes, first in 7:0
    output logic [15:0]             address_out,   // byte address of the word
    output logic                    data_valid_out,
    output logic                    image_valid_out
);

    logic            datapath_reset_n;
    logic            block_reset_n;    // clears quantizer and packer
    logic            capture_enable;
    logic [2:0]      byte_valid;
    logic [2:0][7:0] byte_lanes;
    logic            frame_done;
    logic            last_word;

    assign block_reset_n = reset_pixel_n_in && datapath_reset_n;

    capture_control u_capture_control (
        .clock_pixel_in   (clock_pixel_in),
        .reset_pixel_n_in (reset_pixel_n_in),
        .start_capture_in (start_capture_in),
        .frame_valid_in   (frame_valid_in),
        .last_word        (last_word),
        .datapath_reset_n (datapath_reset_n),
        .capture_enable   (capture_enable),
        .image_valid_out  (image_valid_out)
    );

    color_quantizer u_color_quantizer (
        .clock_pixel_in        (clock_pixel_in),
        .reset_pixel_n_in      (block_reset_n),
        .capture_enable        (capture_enable),
        .frame_valid_in        (frame_valid_in),
        .line_valid_in         (line_valid_in),
        .red_data_in           (red_data_in),
        .green_data_in         (green_data_in),
        .blue_data_in          (blue_data_in),
        .compression_factor_in (compression_factor_in),
        .x_size_in             (x_size_in),
        .y_size_in             (y_size_in),
        .byte_valid            (byte_valid),
        .byte_lanes            (byte_lanes),
        .frame_done            (frame_done)
    );

    word_packer u_word_packer (
        .clock_pixel_in   (clock_pixel_in),
        .reset_pixel_n_in (block_reset_n),
        .byte_valid       (byte_valid),
        .byte_lanes       (byte_lanes),
        .frame_done       (frame_done),
        .data_out         (data_out),
        .address_out      (address_out),
        .data_valid_out   (data_valid_out),
        .last_word        (last_word)
    );

endmodule

// ==== ycc_capture.f ====
hw/ycc_capture_pkg.sv
hw/capture_control.sv
hw/color_quantizer.sv
hw/word_packer.sv
hw/ycc_capture_top.sv
dv/ycc_capture_assert.sv
dv/ycc_capture_tb.sv
